// File: hw/fpu_format_pkg.sv
/* Extended format definitions */

`default_nettype none

package fpu_format_pkg;

    // ========================================
    // Extended precision fields
    // ========================================

    // Biased exponent width
    localparam int EXP_W = 15;

    // Mantissa width with the explicit integer bit
    localparam int MANT_W = 64;

    // Exponent bias of the 80-bit format
    localparam int EXP_BIAS = 16383;

    // Exponent code for infinity and NaN
    localparam logic [EXP_W-1:0] EXP_MAX = '1;

    // Unbiased exponent needs a sign bit and one guard bit
    localparam int EXP_U_W = EXP_W + 2;

    // Sign, exponent, mantissa from the top down
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mantissa;
    } ext_float_t;

    // ========================================
    // Reduced angle
    // ========================================

    // Unsigned fixed point with 2 integer and 62 fraction bits
    localparam int FIX_W = 64;
    typedef logic [FIX_W-1:0] fixed_angle_t;

    // Quadrant index of the folded angle
    localparam int QUAD_W = 2;
    typedef logic [QUAD_W-1:0] quadrant_t;

endpackage

`default_nettype wire

// File: hw/range_bus_pkg.sv
/* Reduction constants and long unit bus */

`default_nettype none

package range_bus_pkg;

    // ========================================
    // Reduction constants
    // ========================================

    // pi/2 truncated to the 2.62 fixed point format
    localparam fpu_format_pkg::fixed_angle_t HALF_PI_FIX = 64'h6487_ED51_10B4_611A;

    // pi/4 is the fold point
    localparam fpu_format_pkg::fixed_angle_t QUARTER_PI_FIX = HALF_PI_FIX >> 1;

    // Largest unbiased exponent handled by repeated subtraction
    localparam int SHORT_EXP_LIMIT = 1;

    // Largest unbiased exponent accepted at all
    localparam int LONG_EXP_LIMIT = 63;

    // Width of the shift count sent to the long unit
    localparam int SHIFT_W = 6;

    // ========================================
    // Wishbone link to the long unit
    // ========================================

    localparam int WB_DATA_W = 64;
    localparam int WB_ADR_W = 2;

    // Mantissa to reduce
    localparam logic [WB_ADR_W-1:0] ADR_MANT = 2'd0;
    // Shift count, a write here starts the computation
    localparam logic [WB_ADR_W-1:0] ADR_SHIFT = 2'd1;
    // Remainder, read stalls until the computation ends
    localparam logic [WB_ADR_W-1:0] ADR_REM = 2'd2;
    // Low two quotient bits
    localparam logic [WB_ADR_W-1:0] ADR_QUAD = 2'd3;

endpackage

`default_nettype wire

// File: hw/fpu_range_reduction.sv
/* Argument reduction channel */

`timescale 1ns/10ps
`default_nettype none

module fpu_range_reduction
    import fpu_format_pkg::*, range_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  ext_float_t           angle_in,
    output fixed_angle_t         angle_out,
    output quadrant_t            quadrant,
    output logic                 swap_sincos,
    output logic                 negate_sin,
    output logic                 negate_cos,
    output logic                 done,
    output logic                 error,
    // Wishbone master toward the shared long unit
    output logic                 m_cyc,
    output logic                 m_stb,
    output logic                 m_we,
    output logic [WB_ADR_W-1:0]  m_adr,
    output logic [WB_DATA_W-1:0] m_dat_w,
    input  logic [WB_DATA_W-1:0] m_dat_r,
    input  logic                 m_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,
        S_SHORT,
        S_LONG,
        S_ADJUST,
        S_FINISH
    } state_t;

    state_t              state;
    // Step within the long transaction
    logic [1:0]          bus_step;

    // Captured operand and working result
    ext_float_t          angle_reg;
    fixed_angle_t        rem;
    quadrant_t           quad;
    logic                fold;
    logic                err;
    logic [SHIFT_W-1:0]  long_shift;

    // Classification
    logic signed [EXP_U_W-1:0] exp_unb;
    logic [EXP_U_W-1:0]        short_shift;
    logic                      is_zero;

    // Sign and fold results
    fixed_angle_t        rem_sign;
    fixed_angle_t        rem_fold;
    quadrant_t           quad_sign;
    logic                fold_next;

    // ========================================
    // Classification
    // ========================================

    always_comb begin
        exp_unb = $signed({2'b00, angle_reg.exponent}) - EXP_U_W'(EXP_BIAS);
        // Right shift that maps the mantissa onto 2.62
        short_shift = EXP_U_W'(1) - exp_unb;
        is_zero = (angle_reg.exponent == '0) && (angle_reg.mantissa == '0);
    end

    // ========================================
    // Sign rule and fold to pi/4
    // ========================================

    always_comb begin
        rem_sign = rem;
        quad_sign = quad;
        if (angle_reg.sign) begin
            if (rem == '0) begin
                // Exact multiple of pi/2
                quad_sign = 2'd0 - quad;
            end else begin
                rem_sign = HALF_PI_FIX - rem;
                // Same as minus q minus 1 modulo 4
                quad_sign = ~quad;
            end
        end
        fold_next = (rem_sign > QUARTER_PI_FIX);
        rem_fold = fold_next ? (HALF_PI_FIX - rem_sign) : rem_sign;
    end

    // ========================================
    // Bus requests
    // ========================================

    // One cyc span covers all four steps
    assign m_cyc = (state == S_LONG);
    assign m_stb = m_cyc;
    // Two writes first, then two reads
    assign m_we = ~bus_step[1];

    always_comb begin
        case (bus_step)
            2'd0:    m_adr = ADR_MANT;
            2'd1:    m_adr = ADR_SHIFT;
            2'd2:    m_adr = ADR_REM;
            default: m_adr = ADR_QUAD;
        endcase
        if (bus_step == 2'd0)
            m_dat_w = angle_reg.mantissa;
        else
            m_dat_w = {{(WB_DATA_W-SHIFT_W){1'b0}}, long_shift};
    end

    // ========================================
    // Control FSM
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            bus_step <= 2'd0;
            err <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Enable outside idle has no effect
                    if (enable) begin
                        angle_reg <= angle_in;
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    quad <= '0;
                    fold <= 1'b0;
                    err <= 1'b0;
                    if (angle_reg.exponent == EXP_MAX || exp_unb > LONG_EXP_LIMIT) begin
                        // Infinity, NaN or out of range
                        err <= 1'b1;
                        state <= S_FINISH;
                    end else if (is_zero) begin
                        rem <= '0;
                        state <= S_ADJUST;
                    end else if (exp_unb <= SHORT_EXP_LIMIT) begin
                        if (short_shift >= EXP_U_W'(FIX_W))
                            rem <= '0;
                        else
                            rem <= angle_reg.mantissa >> short_shift;
                        state <= S_SHORT;
                    end else begin
                        long_shift <= SHIFT_W'(exp_unb - EXP_U_W'(1));
                        bus_step <= 2'd0;
                        state <= S_LONG;
                    end
                end
                S_SHORT: begin
                    // At most two subtractions since the value is below 4
                    if (rem >= HALF_PI_FIX) begin
                        rem <= rem - HALF_PI_FIX;
                        quad <= quad + 2'd1;
                    end else begin
                        state <= S_ADJUST;
                    end
                end
                S_LONG: begin
                    // Request held until ack, arbitration wait included
                    if (m_ack) begin
                        bus_step <= bus_step + 2'd1;
                        if (bus_step == 2'd2)
                            rem <= m_dat_r;
                        if (bus_step == 2'd3) begin
                            quad <= quadrant_t'(m_dat_r);
                            state <= S_ADJUST;
                        end
                    end
                end
                S_ADJUST: begin
                    rem <= rem_fold;
                    quad <= quad_sign;
                    fold <= fold_next;
                    state <= S_FINISH;
                end
                S_FINISH: begin
                    done <= 1'b1;
                    error <= err;
                    // Error zeroes every result
                    if (err) begin
                        angle_out <= '0;
                        quadrant <= '0;
                        swap_sincos <= 1'b0;
                        negate_sin <= 1'b0;
                        negate_cos <= 1'b0;
                    end else begin
                        angle_out <= rem;
                        quadrant <= quad;
                        swap_sincos <= quad[0] ^ fold;
                        negate_sin <= quad[1];
                        negate_cos <= quad[1] ^ quad[0];
                    end
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/wb_arbiter.sv
/* Round-robin Wishbone arbiter */

`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
    import range_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    // Master 0
    input  logic                 m0_cyc,
    input  logic                 m0_stb,
    input  logic                 m0_we,
    input  logic [WB_ADR_W-1:0]  m0_adr,
    input  logic [WB_DATA_W-1:0] m0_dat_w,
    output logic [WB_DATA_W-1:0] m0_dat_r,
    output logic                 m0_ack,
    // Master 1
    input  logic                 m1_cyc,
    input  logic                 m1_stb,
    input  logic                 m1_we,
    input  logic [WB_ADR_W-1:0]  m1_adr,
    input  logic [WB_DATA_W-1:0] m1_dat_w,
    output logic [WB_DATA_W-1:0] m1_dat_r,
    output logic                 m1_ack,
    // Shared slave
    output logic                 s_cyc,
    output logic                 s_stb,
    output logic                 s_we,
    output logic [WB_ADR_W-1:0]  s_adr,
    output logic [WB_DATA_W-1:0] s_dat_w,
    input  logic [WB_DATA_W-1:0] s_dat_r,
    input  logic                 s_ack
);

    // Index of the master that owns the slave
    logic grant;
    logic held_cyc;
    logic other_cyc;

    assign held_cyc = grant ? m1_cyc : m0_cyc;
    assign other_cyc = grant ? m0_cyc : m1_cyc;

    // Grant moves only when the holder has no cyc and the other asks
    always_ff @(posedge clk) begin
        if (reset)
            grant <= 1'b0;
        else if (!held_cyc && other_cyc)
            grant <= ~grant;
    end

    // Request mux toward the slave
    always_comb begin
        s_cyc = held_cyc;
        s_stb = grant ? m1_stb : m0_stb;
        s_we = grant ? m1_we : m0_we;
        s_adr = grant ? m1_adr : m0_adr;
        s_dat_w = grant ? m1_dat_w : m0_dat_w;
    end

    // Read data fans out, ack only reaches the holder
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m0_ack = s_ack && !grant;
    assign m1_ack = s_ack && grant;

endmodule

`default_nettype wire

// File: hw/long_modulo_unit.sv
/* Long modulo by pi/2 */

`timescale 1ns/10ps
`default_nettype none

module long_modulo_unit
    import fpu_format_pkg::*, range_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s_cyc,
    input  logic                 s_stb,
    input  logic                 s_we,
    input  logic [WB_ADR_W-1:0]  s_adr,
    input  logic [WB_DATA_W-1:0] s_dat_w,
    output logic [WB_DATA_W-1:0] s_dat_r,
    output logic                 s_ack
);

    // Written operands
    fixed_angle_t        mant_reg;
    logic [SHIFT_W-1:0]  shift_reg;

    // Working state of the bitwise division
    fixed_angle_t        work_reg;
    fixed_angle_t        rem_reg;
    quadrant_t           quad_reg;
    logic [SHIFT_W:0]    steps_left;
    logic                busy;
    logic                calc_done;

    // One division step
    logic [FIX_W:0]      trial;
    logic                q_bit;
    fixed_angle_t        rem_next;

    // A new access not yet acknowledged
    logic                access;

    assign access = s_cyc && s_stb && !s_ack;

    // ========================================
    // Division step
    // ========================================

    always_comb begin
        // Double the remainder and bring in the next bit
        trial = {rem_reg, work_reg[MANT_W-1]};
        q_bit = (trial >= {1'b0, HALF_PI_FIX});
        if (q_bit)
            rem_next = FIX_W'(trial - {1'b0, HALF_PI_FIX});
        else
            rem_next = FIX_W'(trial);
    end

    // ========================================
    // Bus handshake and sequencing
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            s_ack <= 1'b0;
            busy <= 1'b0;
            calc_done <= 1'b0;
            steps_left <= '0;
        end else begin
            s_ack <= 1'b0;
            if (access) begin
                // Remainder read waits for the end of the computation
                if (!s_we && s_adr == ADR_REM)
                    s_ack <= calc_done;
                else
                    s_ack <= 1'b1;
            end

            if (access && s_we && s_adr == ADR_SHIFT) begin
                // Mantissa bits then shift zero bits
                steps_left <= (SHIFT_W+1)'(MANT_W) + {1'b0, s_dat_w[SHIFT_W-1:0]};
                busy <= 1'b1;
                calc_done <= 1'b0;
            end else if (access && s_we && s_adr == ADR_MANT) begin
                calc_done <= 1'b0;
            end else if (busy) begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == 1) begin
                    busy <= 1'b0;
                    calc_done <= 1'b1;
                end
            end
        end
    end

    // ========================================
    // Datapath
    // ========================================

    always_ff @(posedge clk) begin
        if (access && s_we) begin
            if (s_adr == ADR_MANT)
                mant_reg <= s_dat_w;
            if (s_adr == ADR_SHIFT) begin
                shift_reg <= s_dat_w[SHIFT_W-1:0];
                work_reg <= mant_reg;
                rem_reg <= '0;
                quad_reg <= '0;
            end
        end else if (busy) begin
            // Zeros enter from the bottom once the mantissa is used up
            work_reg <= work_reg << 1;
            rem_reg <= rem_next;
            quad_reg <= {quad_reg[0], q_bit};
        end

        // Read data registered with the ack
        if (access && !s_we) begin
            case (s_adr)
                ADR_MANT:  s_dat_r <= mant_reg;
                ADR_SHIFT: s_dat_r <= {{(WB_DATA_W-SHIFT_W){1'b0}}, shift_reg};
                ADR_REM:   s_dat_r <= rem_reg;
                default:   s_dat_r <= {{(WB_DATA_W-QUAD_W){1'b0}}, quad_reg};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/range_reduction_top.sv
/* Range reduction subsystem */

`timescale 1ns/10ps
`default_nettype none

module range_reduction_top
    import fpu_format_pkg::*, range_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // Channel 0 for sine
    input  logic         enable_0,
    input  ext_float_t   angle_in_0,
    output fixed_angle_t angle_out_0,
    output quadrant_t    quadrant_0,
    output logic         swap_sincos_0,
    output logic         negate_sin_0,
    output logic         negate_cos_0,
    output logic         done_0,
    output logic         error_0,
    // Channel 1 for cosine
    input  logic         enable_1,
    input  ext_float_t   angle_in_1,
    output fixed_angle_t angle_out_1,
    output quadrant_t    quadrant_1,
    output logic         swap_sincos_1,
    output logic         negate_sin_1,
    output logic         negate_cos_1,
    output logic         done_1,
    output logic         error_1
);

    // Master side of each channel
    logic                 m0_cyc, m1_cyc;
    logic                 m0_stb, m1_stb;
    logic                 m0_we, m1_we;
    logic [WB_ADR_W-1:0]  m0_adr, m1_adr;
    logic [WB_DATA_W-1:0] m0_dat_w, m1_dat_w;
    logic [WB_DATA_W-1:0] m0_dat_r, m1_dat_r;
    logic                 m0_ack, m1_ack;

    // Shared slave side
    logic                 s_cyc;
    logic                 s_stb;
    logic                 s_we;
    logic [WB_ADR_W-1:0]  s_adr;
    logic [WB_DATA_W-1:0] s_dat_w;
    logic [WB_DATA_W-1:0] s_dat_r;
    logic                 s_ack;

    fpu_range_reduction sin_channel (
        .clk(clk), .reset(reset), .enable(enable_0), .angle_in(angle_in_0),
        .angle_out(angle_out_0), .quadrant(quadrant_0), .swap_sincos(swap_sincos_0),
        .negate_sin(negate_sin_0), .negate_cos(negate_cos_0), .done(done_0),
        .error(error_0), .m_cyc(m0_cyc), .m_stb(m0_stb), .m_we(m0_we), .m_adr(m0_adr),
        .m_dat_w(m0_dat_w), .m_dat_r(m0_dat_r), .m_ack(m0_ack)
    );

    fpu_range_reduction cos_channel (
        .clk(clk), .reset(reset), .enable(enable_1), .angle_in(angle_in_1),
        .angle_out(angle_out_1), .quadrant(quadrant_1), .swap_sincos(swap_sincos_1),
        .negate_sin(negate_sin_1), .negate_cos(negate_cos_1), .done(done_1),
        .error(error_1), .m_cyc(m1_cyc), .m_stb(m1_stb), .m_we(m1_we), .m_adr(m1_adr),
        .m_dat_w(m1_dat_w), .m_dat_r(m1_dat_r), .m_ack(m1_ack)
    );

    // Sine channel is master 0 and starts with the grant
    wb_arbiter wb_arbiter_inst (
        .clk(clk), .reset(reset),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
        .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
        .m1_dat_w(m1_dat_w), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack),
        .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
        .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
    );

    long_modulo_unit long_modulo_unit_inst (
        .clk(clk), .reset(reset),
        .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
        .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
    );

endmodule

`default_nettype wire

// File: testbench/wb_arbiter_chk.sv
/* Shared bus assertions */

`timescale 1ns/10ps
`default_nettype none

module wb_arbiter_chk (
    input logic clk,
    input logic reset,
    input logic grant,
    input logic m0_stb,
    input logic m1_stb,
    input logic s_cyc,
    input logic s_stb,
    input logic s_ack,
    input logic m0_ack,
    input logic m1_ack
);

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (reset) s_stb |-> s_cyc)
        else $error("slave strobe without cycle");

    // Ack answers a strobe of the previous cycle
    ack_after_stb: assert property (@(posedge clk) disable iff (reset) s_ack |-> $past(s_stb))
        else $error("slave ack without a preceding strobe");

    // Grant held for the whole cyc span
    grant_held: assert property (@(posedge clk) disable iff (reset) s_cyc |=> $stable(grant))
        else $error("grant changed during a cycle");

    // Ack answers only the strobe of the master that held the grant
    m0_ack_owner: assert property (@(posedge clk) disable iff (reset)
        m0_ack |-> $past(!grant && m0_stb))
        else $error("master 0 acked without holding the grant");
    m1_ack_owner: assert property (@(posedge clk) disable iff (reset)
        m1_ack |-> $past(grant && m1_stb))
        else $error("master 1 acked without holding the grant");

endmodule

bind wb_arbiter wb_arbiter_chk wb_arbiter_chk_inst (
    .clk(clk), .reset(reset), .grant(grant),
    .m0_stb(m0_stb), .m1_stb(m1_stb),
    .s_cyc(s_cyc), .s_stb(s_stb), .s_ack(s_ack),
    .m0_ack(m0_ack), .m1_ack(m1_ack)
);

`default_nettype wire

// File: testbench/range_reduction_tb.sv
/* Range reduction testbench */

`timescale 1ns/10ps
`default_nettype none

module range_reduction_tb
    import fpu_format_pkg::*, range_bus_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int DONE_LIMIT = 400;
    // Reductions run by all directed tests together
    localparam int NUM_REDUCTIONS = 72 + 9 + 124 + 5 + 6 + 200;
    localparam longint WATCHDOG_NS = longint'(NUM_REDUCTIONS) * DONE_LIMIT * CLK_PERIOD;

    // Expected response of one channel
    typedef struct packed {
        fixed_angle_t angle;
        quadrant_t    quad;
        logic         swap;
        logic         nsin;
        logic         ncos;
        logic         err;
    } result_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         enable [2];
    ext_float_t   angle_in [2];
    fixed_angle_t angle_out [2];
    quadrant_t    quadrant [2];
    logic         swap_sincos [2];
    logic         negate_sin [2];
    logic         negate_cos [2];
    logic         done [2];
    logic         error [2];

    logic [31:0]  lcg_state = 32'hb8f1_2aeb;

    always #(CLK_PERIOD / 2) clk = ~clk;

    range_reduction_top range_reduction_top_inst (
        .clk(clk), .reset(reset),
        .enable_0(enable[0]), .angle_in_0(angle_in[0]), .angle_out_0(angle_out[0]),
        .quadrant_0(quadrant[0]), .swap_sincos_0(swap_sincos[0]),
        .negate_sin_0(negate_sin[0]), .negate_cos_0(negate_cos[0]),
        .done_0(done[0]), .error_0(error[0]),
        .enable_1(enable[1]), .angle_in_1(angle_in[1]), .angle_out_1(angle_out[1]),
        .quadrant_1(quadrant[1]), .swap_sincos_1(swap_sincos[1]),
        .negate_sin_1(negate_sin[1]), .negate_cos_1(negate_cos[1]),
        .done_1(done[1]), .error_1(error[1])
    );

    // ========================================
    // Reference model and stimulus helpers
    // ========================================

    function automatic result_t model_reduce(input ext_float_t a);
        result_t      r;
        int           e;
        logic [127:0] n;
        logic [127:0] h;
        fixed_angle_t rem;
        quadrant_t    q;
        logic         fold;
        r = '0;
        e = int'(a.exponent) - EXP_BIAS;
        // Infinity, NaN and huge exponents are errors with zero results
        if (a.exponent == EXP_MAX || e > LONG_EXP_LIMIT) begin
            r.err = 1'b1;
            return r;
        end
        // Angle scaled by 2^62 as a wide integer
        h = {64'd0, HALF_PI_FIX};
        if (e >= 1)
            n = {64'd0, a.mantissa} << (e - 1);
        else if (e <= -63)
            n = '0;
        else
            n = {64'd0, a.mantissa >> (1 - e)};
        rem = fixed_angle_t'(n % h);
        q = quadrant_t'(n / h);
        if (a.sign) begin
            if (rem == '0) begin
                q = 2'd0 - q;
            end else begin
                rem = HALF_PI_FIX - rem;
                q = 2'd3 - q;
            end
        end
        // Fold into [0, pi/4]
        fold = (rem > QUARTER_PI_FIX);
        if (fold)
            rem = HALF_PI_FIX - rem;
        r.angle = rem;
        r.quad = q;
        r.swap = q[0] ^ fold;
        r.nsin = q[1];
        r.ncos = q[1] ^ q[0];
        return r;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [MANT_W-1:0] normalized_mantissa();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        // Normalized with the integer bit set
        return {1'b1, hi[30:0], lo};
    endfunction

    function automatic ext_float_t build_angle(input logic sign, input int e,
                                               input logic [MANT_W-1:0] mant);
        ext_float_t a;
        a.sign = sign;
        a.exponent = EXP_W'(EXP_BIAS + e);
        a.mantissa = mant;
        return a;
    endfunction

    // ========================================
    // Failure reporting and compare tasks
    // ========================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_angle(input int ch, input fixed_angle_t got, input fixed_angle_t want);
        if (got !== want)
            report_failure($sformatf("error %0d ns: channel %0d angle_out %h, expected %h",
                                     $time, ch, got, want));
    endtask

    task automatic check_quadrant(input int ch, input quadrant_t got, input quadrant_t want);
        if (got !== want)
            report_failure($sformatf("error %0d ns: channel %0d quadrant %0d, expected %0d",
                                     $time, ch, got, want));
    endtask

    // Flags in the order swap, negate sin, negate cos
    task automatic check_flags(input int ch, input logic [2:0] got, input logic [2:0] want);
        if (got !== want)
            report_failure($sformatf("error %0d ns: channel %0d flags %b, expected %b",
                                     $time, ch, got, want));
    endtask

    task automatic check_error(input int ch, input logic got, input logic want);
        if (got !== want)
            report_failure($sformatf("error %0d ns: channel %0d error %b, expected %b",
                                     $time, ch, got, want));
    endtask

    // ========================================
    // Channel sequencing
    // ========================================

    // Waits for done and compares every result output
    task automatic collect_result(input int ch, input ext_float_t a);
        result_t want;
        int      cycles;
        want = model_reduce(a);
        cycles = 0;
        while (done[ch] !== 1'b1) begin
            if (cycles == DONE_LIMIT)
                report_failure($sformatf("channel %0d did not finish within %0d cycles",
                                         ch, DONE_LIMIT));
            @(negedge clk);
            cycles++;
        end
        check_error(ch, error[ch], want.err);
        check_angle(ch, angle_out[ch], want.angle);
        check_quadrant(ch, quadrant[ch], want.quad);
        check_flags(ch, {swap_sincos[ch], negate_sin[ch], negate_cos[ch]},
                    {want.swap, want.nsin, want.ncos});
    endtask

    task automatic single_reduction(input int ch, input ext_float_t a, input logic poke_busy);
        ext_float_t junk;
        junk = '{~a.sign, a.exponent, ~a.mantissa};
        @(negedge clk);
        enable[ch] = 1'b1;
        angle_in[ch] = a;
        @(negedge clk);
        enable[ch] = 1'b0;
        if (poke_busy) begin
            // Second start while busy must not disturb the result
            @(negedge clk);
            enable[ch] = 1'b1;
            angle_in[ch] = junk;
            @(negedge clk);
            enable[ch] = 1'b0;
        end
        collect_result(ch, a);
    endtask

    // Both channels start in the same cycle
    task automatic paired_reduction(input ext_float_t a0, input ext_float_t a1);
        @(negedge clk);
        enable[0] = 1'b1;
        enable[1] = 1'b1;
        angle_in[0] = a0;
        angle_in[1] = a1;
        @(negedge clk);
        enable[0] = 1'b0;
        enable[1] = 1'b0;
        fork
            collect_result(0, a0);
            collect_result(1, a1);
        join
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic small_positive_sweep();
        int e;
        for (e = -70; e <= SHORT_EXP_LIMIT; e++)
            single_reduction(0, build_angle(1'b0, e, normalized_mantissa()), 1'b0);
    endtask

    task automatic negative_angles();
        single_reduction(0, build_angle(1'b1, -3, normalized_mantissa()), 1'b0);
        single_reduction(0, build_angle(1'b1, 0, normalized_mantissa()), 1'b0);
        single_reduction(1, build_angle(1'b1, 1, normalized_mantissa()), 1'b0);
        single_reduction(0, build_angle(1'b1, 5, normalized_mantissa()), 1'b0);
        single_reduction(1, build_angle(1'b1, 40, normalized_mantissa()), 1'b0);
        // Exact multiples of pi/2 give a zero remainder
        single_reduction(0, build_angle(1'b1, 0, HALF_PI_FIX << 1), 1'b0);
        single_reduction(1, build_angle(1'b1, 1, HALF_PI_FIX << 1), 1'b0);
        single_reduction(0, build_angle(1'b1, 2, HALF_PI_FIX), 1'b0);
        single_reduction(1, build_angle(1'b1, 3, HALF_PI_FIX), 1'b0);
    endtask

    task automatic large_exponent_sweep();
        int e;
        int ch;
        for (ch = 0; ch < 2; ch++)
            for (e = SHORT_EXP_LIMIT + 1; e <= LONG_EXP_LIMIT; e++)
                single_reduction(ch, build_angle(1'b0, e, normalized_mantissa()), 1'b0);
    endtask

    task automatic special_inputs();
        single_reduction(0, '{1'b0, 15'd0, 64'd0}, 1'b0);
        // Infinity, NaN and a NaN without the integer bit
        single_reduction(1, '{1'b0, EXP_MAX, 64'h8000_0000_0000_0000}, 1'b0);
        single_reduction(0, '{1'b0, EXP_MAX, 64'hC000_0000_0000_0000}, 1'b0);
        single_reduction(1, '{1'b1, EXP_MAX, 64'h0000_0000_0000_0001}, 1'b0);
        single_reduction(0, build_angle(1'b0, LONG_EXP_LIMIT + 1, normalized_mantissa()), 1'b0);
    endtask

    task automatic simultaneous_starts();
        ext_float_t a0;
        ext_float_t a1;
        repeat (3) begin
            a0 = build_angle(1'b0, 2 + int'(lcg_next() % 32'd62), normalized_mantissa());
            a1 = build_angle(1'b1, 2 + int'(lcg_next() % 32'd62), normalized_mantissa());
            paired_reduction(a0, a1);
        end
    endtask

    task automatic mixed_random_angles();
        logic [31:0] r;
        int          i;
        int          e;
        for (i = 0; i < 200; i++) begin
            r = lcg_next();
            // Exponents from -10 to 65 reach every path
            e = int'(r[31:24] % 8'd76) - 10;
            single_reduction(int'(r[16]), build_angle(r[5], e, normalized_mantissa()), r[9]);
        end
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================

    initial begin
        reset = 1'b1;
        enable[0] = 1'b0;
        enable[1] = 1'b0;
        angle_in[0] = '0;
        angle_in[1] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        small_positive_sweep();
        negative_angles();
        large_exponent_sweep();
        special_inputs();
        simultaneous_starts();
        mixed_random_angles();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

// File: tb.f
hw/fpu_format_pkg.sv
hw/range_bus_pkg.sv
hw/fpu_range_reduction.sv
hw/wb_arbiter.sv
hw/long_modulo_unit.sv
hw/range_reduction_top.sv
testbench/wb_arbiter_chk.sv
testbench/range_reduction_tb.sv

// File: Makefile
# Verilator build and run of the range reduction testbench

VERILATOR  ?= verilator
TOP        ?= range_reduction_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --assert --timing
LINT_FLAGS ?= -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(BINARY)
	./$(BINARY)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
